// File: src/firTypesPkg.sv
package firTypesPkg;

	// word width of samples, products and partial sums
	localparam int SAMPLE_W = 18;

	// all arithmetic on this type wraps modulo 2^18
	typedef logic signed [SAMPLE_W-1:0] sampleT;

	// filter length, odd so there is a single centre tap
	localparam int FILT_LEN = 21;

	// stored half of the table, centre included
	localparam int HALF_LEN = (FILT_LEN + 1) / 2;

	// positive symbol amplitudes
	// negative levels are their negations
	localparam sampleT LEVEL_POS1 = 18'sd32768;
	localparam sampleT LEVEL_POS3 = 18'sd98303;

	// half width of the acceptance window around each level
	localparam int DEFAULT_TOL = 10;

endpackage

// File: src/pulseCoefPkg.sv
package pulseCoefPkg;

	import firTypesPkg::*;

	// coefficients for the +1 level, outer tap first, centre last
	localparam sampleT coefPos1 [0:HALF_LEN-1] = '{
		18'sd990,
		18'sd948,
		18'sd234,
		-18'sd859,
		-18'sd1706,
		-18'sd1629,
		-18'sd246,
		18'sd2272,
		18'sd5204,
		18'sd7548,
		18'sd8442
	};

	// coefficients for the +3 level, same ordering
	localparam sampleT coefPos3 [0:HALF_LEN-1] = '{
		18'sd2969,
		18'sd2844,
		18'sd702,
		-18'sd2577,
		-18'sd5119,
		-18'sd4886,
		-18'sd739,
		18'sd6815,
		18'sd15613,
		18'sd22645,
		18'sd25327
	};

	// tap index to half-table entry, mirrored taps share one entry
	function automatic int foldIndex(input int tapIndex);
		int mirror;
		mirror = FILT_LEN - 1 - tapIndex;
		return (tapIndex < mirror) ? tapIndex : mirror;
	endfunction

endpackage

// File: src/symbolDelayLine.sv
`timescale 1ns/1ns

module symbolDelayLine
	import firTypesPkg::*;
#(
	parameter int DEPTH = 2
) (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input sampleT xIn,
	output sampleT [DEPTH-1:0] taps
);

	// newest sample sits at position 0
	sampleT [DEPTH-1:0] chain;

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			chain <= '0;
		end else if (sam_clk_en) begin
			chain <= {chain[DEPTH-2:0], xIn};
		end
	end

	assign taps = chain;

endmodule

// File: src/tapLookup.sv
`timescale 1ns/1ns

module tapLookup
	import firTypesPkg::*;
	import pulseCoefPkg::*;
#(
	parameter int TOL = DEFAULT_TOL,
	parameter int TAP_INDEX = 0
) (
	input sampleT sample,
	output sampleT product
);

	// this tap's entries in the half table
	localparam int FOLD_POS = foldIndex(TAP_INDEX);
	localparam sampleT COEF1 = coefPos1[FOLD_POS];
	localparam sampleT COEF3 = coefPos3[FOLD_POS];

	// true when value lies strictly inside the window around level
	function automatic logic inWindow(input sampleT value, input int level);
		int diff;
		diff = int'(value) - level;
		return (diff > -TOL) && (diff < TOL);
	endfunction

	logic nearPos1;
	logic nearNeg1;
	logic nearPos3;
	logic nearNeg3;

	// compare in 32 bits so the window edges cannot wrap
	assign nearPos1 = inWindow(sample, int'(LEVEL_POS1));
	assign nearNeg1 = inWindow(sample, -int'(LEVEL_POS1));
	assign nearPos3 = inWindow(sample, int'(LEVEL_POS3));
	assign nearNeg3 = inWindow(sample, -int'(LEVEL_POS3));

	// windows are disjoint, so at most one match is active
	always_comb begin
		if (nearPos3) begin
			product = COEF3;
		end else if (nearPos1) begin
			product = COEF1;
		end else if (nearNeg1) begin
			product = -COEF1;
		end else if (nearNeg3) begin
			product = -COEF3;
		end else begin
			// off-level sample contributes nothing
			product = '0;
		end
	end

endmodule

// File: src/symmetricFold.sv
`timescale 1ns/1ns

module symmetricFold
	import firTypesPkg::*;
#(
	parameter int TAPS = 3
) (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input sampleT [TAPS-1:0] products,
	output sampleT [(TAPS+1)/2-1:0] foldSums
);

	localparam int HALF = (TAPS + 1) / 2;

	for (genvar i = 0; i < HALF; i++) begin : gFold
		if (2 * i == TAPS - 1) begin : gCentre
			// centre tap has no mirror partner
			always_ff @(posedge sys_clk) begin
				if (reset) begin
					foldSums[i] <= '0;
				end else if (sam_clk_en) begin
					foldSums[i] <= products[i];
				end
			end
		end else begin : gPair
			// mirrored taps share a coefficient, add before the tree
			always_ff @(posedge sys_clk) begin
				if (reset) begin
					foldSums[i] <= '0;
				end else if (sam_clk_en) begin
					foldSums[i] <= products[i] + products[TAPS-1-i];
				end
			end
		end
	end

endmodule

// File: src/treeStage.sv
`timescale 1ns/1ns

module treeStage
	import firTypesPkg::*;
#(
	parameter int IN_COUNT = 2
) (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input sampleT [IN_COUNT-1:0] sumsIn,
	output sampleT [(IN_COUNT+1)/2-1:0] sumsOut
);

	localparam int OUT_COUNT = (IN_COUNT + 1) / 2;

	for (genvar o = 0; o < OUT_COUNT; o++) begin : gOut
		if (2 * o + 1 < IN_COUNT) begin : gPair
			always_ff @(posedge sys_clk) begin
				if (reset) begin
					sumsOut[o] <= '0;
				end else if (sam_clk_en) begin
					sumsOut[o] <= sumsIn[2*o] + sumsIn[2*o+1];
				end
			end
		end else begin : gPass
			// leftover odd entry moves up one level unchanged
			always_ff @(posedge sys_clk) begin
				if (reset) begin
					sumsOut[o] <= '0;
				end else if (sam_clk_en) begin
					sumsOut[o] <= sumsIn[2*o];
				end
			end
		end
	end

endmodule

// File: src/pamFirTop.sv
`timescale 1ns/1ns

module pamFirTop
	import firTypesPkg::*;
#(
	parameter int TOL = DEFAULT_TOL
) (
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input sampleT xIn,
	output sampleT y
);

	// entry counts of each summation level
	localparam int STAGE2_LEN = (HALF_LEN + 1) / 2;
	localparam int STAGE3_LEN = (STAGE2_LEN + 1) / 2;
	localparam int STAGE4_LEN = (STAGE3_LEN + 1) / 2;

	sampleT [FILT_LEN-1:0] taps;
	sampleT [FILT_LEN-1:0] products;
	sampleT [HALF_LEN-1:0] foldSums;
	sampleT [STAGE2_LEN-1:0] stage2;
	sampleT [STAGE3_LEN-1:0] stage3;
	sampleT [STAGE4_LEN-1:0] stage4;

	symbolDelayLine #(
		.DEPTH(FILT_LEN)
	) i_symbolDelayLine (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.xIn(xIn),
		.taps(taps)
	);

	// one coefficient lookup per tap, no multipliers
	for (genvar t = 0; t < FILT_LEN; t++) begin : gTap
		tapLookup #(
			.TOL(TOL),
			.TAP_INDEX(t)
		) i_tapLookup (
			.sample(taps[t]),
			.product(products[t])
		);
	end

	symmetricFold #(
		.TAPS(FILT_LEN)
	) i_symmetricFold (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.products(products),
		.foldSums(foldSums)
	);

	// four registered levels, 11 -> 6 -> 3 -> 2 -> 1
	treeStage #(
		.IN_COUNT(HALF_LEN)
	) i_treeStage2 (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.sumsIn(foldSums),
		.sumsOut(stage2)
	);

	treeStage #(
		.IN_COUNT(STAGE2_LEN)
	) i_treeStage3 (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.sumsIn(stage2),
		.sumsOut(stage3)
	);

	treeStage #(
		.IN_COUNT(STAGE3_LEN)
	) i_treeStage4 (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.sumsIn(stage3),
		.sumsOut(stage4)
	);

	// last level has a single entry, which is the filter output
	treeStage #(
		.IN_COUNT(STAGE4_LEN)
	) i_treeStage5 (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.sumsIn(stage4),
		.sumsOut(y)
	);

endmodule

// File: tb/pamFir_props.sv
`timescale 1ns/1ns

module pamFirProps
	import firTypesPkg::*;
(
	input logic sys_clk,
	input logic reset,
	input logic sam_clk_en,
	input sampleT y,
	input sampleT [FILT_LEN-1:0] taps
);

	// count of failed assertions
	int failCount = 0;

	// every register clears on reset
	yZeroAfterReset: assert property (
		@(posedge sys_clk) reset |=> (y == '0)
	) else begin
		failCount++;
		$error("y not zero in the cycle after reset");
	end

	// y moves only on a strobe
	yHoldsWithoutEnable: assert property (
		@(posedge sys_clk) (!sam_clk_en && !reset) |=> $stable(y)
	) else begin
		failCount++;
		$error("y changed without a sample enable");
	end

	tapShifts: assert property (
		@(posedge sys_clk) (sam_clk_en && !reset) |=> (taps[1] == $past(taps[0]))
	) else begin
		failCount++;
		$error("tap 1 did not take the previous tap 0 on an enable");
	end

endmodule

bind pamFirTop pamFirProps i_pamFirProps (
	.sys_clk(sys_clk),
	.reset(reset),
	.sam_clk_en(sam_clk_en),
	.y(y),
	.taps(taps)
);

// File: tb/pamFirTb.sv
`timescale 1ns/1ns

module pamFirTb
	import firTypesPkg::*;
	import pulseCoefPkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DLY = 2;
	localparam int TB_TOL = DEFAULT_TOL;
	// enables from a window entering the delay line to its sum on y
	localparam int LATENCY = 5;

	localparam int EXACT_ENABLES = 200;
	localparam int LEAD_ZEROS = FILT_LEN + LATENCY;
	localparam int TAIL_ZEROS = FILT_LEN + LATENCY - 1;
	localparam int IMPULSE_ENABLES = LEAD_ZEROS + 1 + TAIL_ZEROS;
	localparam int TOL_ENABLES = 150;
	localparam int HOLD_ENABLES = 60;
	localparam int TOTAL_ENABLES = EXACT_ENABLES + IMPULSE_ENABLES + TOL_ENABLES + HOLD_ENABLES;
	localparam int WATCHDOG_NS = (TOTAL_ENABLES * 5 + 50) * CLK_PERIOD;

	logic sys_clk;
	logic reset;
	logic sam_clk_en;
	sampleT xIn;
	sampleT y;

	// reference model state
	sampleT window [FILT_LEN];
	sampleT expQ [$];
	sampleT heldExp;

	int errorCount;
	int checkCount;
	int assertFails;
	bit [31:0] lcgState = 32'd53044;

	pamFirTop #(
		.TOL(TB_TOL)
	) i_pamFirTop (
		.sys_clk(sys_clk),
		.reset(reset),
		.sam_clk_en(sam_clk_en),
		.xIn(xIn),
		.y(y)
	);

	initial begin
		sys_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) sys_clk = ~sys_clk;
		end
	end

	function automatic int nextRandom();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[30:16]);
	endfunction

	function automatic int randomBelow(input int n);
		return nextRandom() % n;
	endfunction

	function automatic int pickLevel();
		case (randomBelow(4))
			0: return int'(LEVEL_POS1);
			1: return -int'(LEVEL_POS1);
			2: return int'(LEVEL_POS3);
			default: return -int'(LEVEL_POS3);
		endcase
	endfunction

	// strictly inside the tolerance window
	function automatic bit nearLevel(input sampleT s, input int level);
		int d;
		d = int'(s) - level;
		if (d < 0) begin
			d = -d;
		end
		return d < TB_TOL;
	endfunction

	function automatic sampleT tapContribution(input int tap, input sampleT s);
		int mirror;
		int entry;
		mirror = FILT_LEN - 1 - tap;
		entry = (tap < mirror) ? tap : mirror;
		if (nearLevel(s, int'(LEVEL_POS1))) begin
			return coefPos1[entry];
		end else if (nearLevel(s, -int'(LEVEL_POS1))) begin
			return -coefPos1[entry];
		end else if (nearLevel(s, int'(LEVEL_POS3))) begin
			return coefPos3[entry];
		end else if (nearLevel(s, -int'(LEVEL_POS3))) begin
			return -coefPos3[entry];
		end
		return '0;
	endfunction

	// 18-bit accumulator wraps like the hardware
	function automatic sampleT windowSum();
		sampleT acc;
		acc = '0;
		for (int t = 0; t < FILT_LEN; t++) begin
			acc = acc + tapContribution(t, window[t]);
		end
		return acc;
	endfunction

	task automatic checkSample(input string name, input sampleT expected, input sampleT actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic clearModel();
		for (int t = 0; t < FILT_LEN; t++) begin
			window[t] = '0;
		end
		expQ.delete();
		heldExp = '0;
	endtask

	// y must not move while the strobe is low
	task automatic idleCycles(input string name, input int n);
		repeat (n) begin
			@(posedge sys_clk);
			#DRIVE_DLY;
			checkSample(name, heldExp, y);
		end
	endtask

	task automatic applyReset(input int cycles);
		reset = 1'b1;
		sam_clk_en = 1'b0;
		repeat (cycles) begin
			@(posedge sys_clk);
			#DRIVE_DLY;
			checkSample("reset", '0, y);
		end
		reset = 1'b0;
		clearModel();
	endtask

	task automatic applyEnable(input string name, input sampleT x, input int gap);
		sampleT expected;
		sam_clk_en = 1'b1;
		xIn = x;
		@(posedge sys_clk);
		#DRIVE_DLY;
		sam_clk_en = 1'b0;
		// idle junk must never be captured
		xIn = sampleT'(nextRandom() * 8 - 131072);
		for (int i = FILT_LEN - 1; i > 0; i--) begin
			window[i] = window[i-1];
		end
		window[0] = x;
		expQ.push_back(windowSum());
		if (expQ.size() > LATENCY) begin
			expected = expQ.pop_front();
		end else begin
			expected = '0;
		end
		heldExp = expected;
		checkSample(name, expected, y);
		idleCycles({name, " hold"}, gap);
	endtask

	task automatic runExactStream();
		int level;
		int gap;
		repeat (EXACT_ENABLES) begin
			level = pickLevel();
			gap = randomBelow(4);
			applyEnable("exact stream", sampleT'(level), gap);
		end
	endtask

	// lone +3 symbol walks through every tap
	task automatic runImpulse();
		int m;
		int mirror;
		repeat (LEAD_ZEROS) begin
			applyEnable("impulse lead", '0, randomBelow(4));
		end
		applyEnable("impulse", LEVEL_POS3, 0);
		for (int c = 1; c <= TAIL_ZEROS; c++) begin
			applyEnable("impulse tail", '0, randomBelow(4));
			m = c - LATENCY;
			mirror = FILT_LEN - 1 - m;
			if (m >= 0) begin
				checkSample("impulse trace", coefPos3[(m < mirror) ? m : mirror], y);
			end
		end
	endtask

	task automatic runTolerance();
		int level;
		int offset;
		int gap;
		sampleT x;
		repeat (TOL_ENABLES) begin
			level = pickLevel();
			offset = randomBelow(2 * TB_TOL + 7) - (TB_TOL + 3);
			x = sampleT'(level + offset);
			// now and then a sample far from every level
			if (randomBelow(8) == 0) begin
				x = sampleT'(nextRandom() * 8 - 131072);
			end
			gap = randomBelow(4);
			applyEnable("tolerance", x, gap);
		end
	endtask

	task automatic runHoldAndReset();
		repeat (HOLD_ENABLES / 2) begin
			applyEnable("pre reset", sampleT'(pickLevel()), randomBelow(4));
		end
		idleCycles("long idle", 8);
		applyReset(3);
		idleCycles("after mid reset", 3);
		repeat (HOLD_ENABLES / 2) begin
			applyEnable("post reset", sampleT'(pickLevel()), randomBelow(4));
		end
	endtask

	initial begin
		reset = 1'b1;
		sam_clk_en = 1'b0;
		xIn = '0;
		errorCount = 0;
		checkCount = 0;
		assertFails = 0;
		clearModel();
		applyReset(10);
		idleCycles("after reset", 4);
		runExactStream();
		runImpulse();
		runTolerance();
		runHoldAndReset();
		assertFails = i_pamFirTop.i_pamFirProps.failCount;
		$display("checks: %0d, errors: %0d, assertion failures: %0d",
			checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: stimulus did not complete within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
src/firTypesPkg.sv
src/pulseCoefPkg.sv
src/symbolDelayLine.sv
src/tapLookup.sv
src/symmetricFold.sv
src/treeStage.sv
src/pamFirTop.sv
tb/pamFir_props.sv
tb/pamFirTb.sv

// File: run.sh
#!/bin/sh
# Build and run the PAM FIR testbench with Verilator.
# Exit status is non-zero unless the pass line shows up in the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module pamFirTb -f vlog.f -o simPamFir > "$BUILD_LOG" 2>&1 \
	|| { cat "$BUILD_LOG"; echo "build failed"; exit 1; }

./obj_dir/simPamFir > "$SIM_LOG" 2>&1
cat "$SIM_LOG"

grep -q "^ALL CHECKS PASSED$" "$SIM_LOG" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
